/* vlog.f */
common/asic_pkg.sv
source/port_regs.sv
source/mem_pager.sv
video/video_timing.sv
video/palette_out.sv
source/asic_top.sv
tb/tb_clock.sv
tb/asic_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the asic_tb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module asic_tb -f vlog.f -o Vasic_tb

./obj_dir/Vasic_tb 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* tb/asic_tb.sv */
`timescale 1ns/1ps

module asic_tb;

    // Frame geometry and port numbers
    localparam int     H_TOTAL      = 768;
    localparam int     V_TOTAL      = 312;
    localparam int     HB_START     = 64;
    localparam int     HB_END       = 208;
    localparam int     HS_START     = 80;
    localparam int     HS_END       = 144;
    localparam int     VB_START     = 240;
    localparam int     VB_END       = 264;
    localparam int     VS_LINE      = 244;
    localparam int     VS_END       = 248;
    localparam int     INT_CLKS     = 256;
    localparam int     CLK_NS       = 20;
    localparam longint FRAME_NS     = longint'(H_TOTAL) * V_TOTAL * CLK_NS;
    // Four frame-long waits at most, plus the register tests
    localparam longint TIMEOUT_NS   = 5 * FRAME_NS;
    localparam logic [7:0] CLUT_PORT   = 8'd248;
    localparam logic [7:0] STATUS_PORT = 8'd249;
    localparam logic [7:0] LMPR_PORT   = 8'd250;
    localparam logic [7:0] HMPR_PORT   = 8'd251;
    localparam logic [7:0] VMPR_PORT   = 8'd252;
    localparam logic [7:0] BORDER_PORT = 8'd254;

    logic        clk;
    logic        rst_n;
    logic        mreq_n, iorq_n, rd_n, wr_n, ear;
    logic [15:0] cpuaddr;
    logic [7:0]  data_from_cpu, keyboard, data_to_cpu;
    logic        data_enable_n, romcs_n, ramcs_n, ramwr_n;
    logic [18:0] cpuramaddr;
    logic        mic, beep, bright, csync, hsync_pal, vsync_pal, int_n;
    logic [1:0]  r, g, b;

    // Reference model state
    logic [7:0]  lmpr_m, hmpr_m, vmpr_m, border_m, line_m;
    logic [6:0]  clut_m [16];
    logic [9:0]  hc_m;
    logic [8:0]  vc_m;

    tb_clock #(.PERIOD_NS(CLK_NS)) clock_i (.clk(clk));

    asic_top dut_i (
        .clk (clk), .rst_n (rst_n),
        .mreq_n (mreq_n), .iorq_n (iorq_n), .rd_n (rd_n), .wr_n (wr_n),
        .cpuaddr (cpuaddr), .data_from_cpu (data_from_cpu),
        .keyboard (keyboard), .ear (ear),
        .data_to_cpu (data_to_cpu), .data_enable_n (data_enable_n),
        .cpuramaddr (cpuramaddr), .romcs_n (romcs_n), .ramcs_n (ramcs_n),
        .ramwr_n (ramwr_n), .mic (mic), .beep (beep),
        .r (r), .g (g), .b (b), .bright (bright), .csync (csync),
        .hsync_pal (hsync_pal), .vsync_pal (vsync_pal), .int_n (int_n)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s mismatch, got 0x%0h expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "check mismatch");
        end
    endtask

    //////////////////////////////
    // Model
    //////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            hc_m <= '0;
            vc_m <= '0;
        end else if (hc_m == 10'(H_TOTAL - 1)) begin
            hc_m <= '0;
            vc_m <= (vc_m == 9'(V_TOTAL - 1)) ? 9'd0 : vc_m + 9'd1;
        end else begin
            hc_m <= hc_m + 10'd1;
        end
    end

    function automatic logic vint_active();
        return vc_m == 9'(VS_LINE) && hc_m < 10'(INT_CLKS);
    endfunction

    function automatic logic rint_active();
        return line_m <= 8'd191 && {1'b0, line_m} == vc_m && hc_m < 10'(INT_CLKS);
    endfunction

    function automatic logic hsync_expected();
        return !(hc_m >= 10'(HS_START) && hc_m < 10'(HS_END));
    endfunction

    function automatic logic vsync_expected();
        return !(vc_m >= 9'(VS_LINE) && vc_m < 9'(VS_END));
    endfunction

    // Bit 8 is the expected data_enable_n
    function automatic logic [8:0] expected_read(input logic [7:0] port);
        case (port)
            BORDER_PORT: return {1'b0, border_m[7] & vmpr_m[6], ear, 1'b0, keyboard[4:0]};
            STATUS_PORT: return {1'b0, keyboard[7:5], 1'b1, !vint_active(), 2'b11,
                                 !rint_active()};
            VMPR_PORT:   return {1'b0, vmpr_m};
            HMPR_PORT:   return {1'b0, hmpr_m};
            LMPR_PORT:   return {1'b0, lmpr_m};
            default:     return 9'h1ff;
        endcase
    endfunction

    function automatic logic [6:0] expected_rgb();
        logic [6:0] e;
        logic       blank;
        e = clut_m[{border_m[5], border_m[2:0]}];
        blank = (border_m[7] && vmpr_m[6]) ||
                (hc_m >= 10'(HB_START) && hc_m < 10'(HB_END)) ||
                (vc_m >= 9'(VB_START) && vc_m < 9'(VB_END));
        if (blank) begin
            return 7'd0;
        end
        // {r, g, b, bright} from g_hi r_hi b_hi bright g_lo r_lo b_lo
        return {e[5], e[1], e[6], e[2], e[4], e[0], e[3]};
    endfunction

    // Continuous checks on int_n, syncs and colour
    always @(negedge clk) begin
        if (rst_n) begin
            check_value(int_n, !(vint_active() || rint_active()), "int_n");
            check_value(hsync_pal, hsync_expected(), "hsync_pal");
            check_value(vsync_pal, vsync_expected(), "vsync_pal");
            check_value(csync, vsync_expected() ? hsync_expected() : !hsync_expected(),
                        "csync");
            check_value({r, g, b, bright}, expected_rgb(), "rgb");
        end
    end

    //////////////////////////////
    // Bus cycles
    //////////////////////////////
    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpuaddr       <= addr;
        data_from_cpu <= data;
        iorq_n        <= 1'b0;
        wr_n          <= 1'b0;
        @(posedge clk);
        iorq_n        <= 1'b1;
        wr_n          <= 1'b1;
        // DUT register took the value at this edge
        case (addr[7:0])
            BORDER_PORT: border_m = data;
            VMPR_PORT:   vmpr_m   = data;
            HMPR_PORT:   hmpr_m   = data;
            LMPR_PORT:   lmpr_m   = data;
            STATUS_PORT: line_m   = data;
            CLUT_PORT:   clut_m[addr[11:8]] = data[6:0];
            default: ;
        endcase
    endtask

    task automatic read_check(input logic [15:0] addr, input string what,
                              output logic [7:0] data);
        logic [8:0] exp;
        @(posedge clk);
        cpuaddr <= addr;
        iorq_n  <= 1'b0;
        rd_n    <= 1'b0;
        @(negedge clk);
        exp  = expected_read(addr[7:0]);
        data = data_to_cpu;
        check_value(data_enable_n, exp[8], {what, " data_enable_n"});
        check_value(data_to_cpu, exp[7:0], what);
        @(posedge clk);
        iorq_n <= 1'b1;
        rd_n   <= 1'b1;
    endtask

    task automatic mem_check(input logic [15:0] addr, input logic write);
        logic [1:0] sec;
        logic       rom, ram;
        logic [4:0] page;
        @(posedge clk);
        cpuaddr <= addr;
        mreq_n  <= 1'b0;
        rd_n    <= write;
        wr_n    <= !write;
        @(negedge clk);
        sec = addr[15:14];
        rom = (sec == 2'd0 && !lmpr_m[5]) || (sec == 2'd3 && lmpr_m[6]);
        ram = !rom && !(addr[15] && hmpr_m[7]);
        case (sec)
            2'd0:    page = lmpr_m[4:0];
            2'd1:    page = lmpr_m[4:0] + 5'd1;
            2'd2:    page = hmpr_m[4:0];
            default: page = hmpr_m[4:0] + 5'd1;
        endcase
        check_value(romcs_n, !rom, "romcs_n");
        check_value(ramcs_n, !ram, "ramcs_n");
        check_value(ramwr_n, !(ram && write && !(sec == 2'd0 && lmpr_m[7])), "ramwr_n");
        check_value(cpuramaddr, {page, addr[13:0]}, "cpuramaddr");
        @(posedge clk);
        mreq_n <= 1'b1;
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic paging_cycles();
        for (int round = 0; round < 4; round++) begin
            io_write({8'($urandom), LMPR_PORT}, 8'($urandom));
            io_write({8'($urandom), HMPR_PORT}, 8'($urandom));
            for (int i = 0; i < 50; i++) begin
                mem_check(16'($urandom), 1'($urandom));
            end
        end
    endtask

    task automatic register_readback();
        logic [7:0] d;
        logic [7:0] port;
        for (int i = 0; i < 20; i++) begin
            io_write({8'($urandom), VMPR_PORT}, 8'($urandom));
            io_write({8'($urandom), LMPR_PORT}, 8'($urandom));
            io_write({8'($urandom), HMPR_PORT}, 8'($urandom));
            read_check({8'($urandom), VMPR_PORT}, "VMPR read", d);
            read_check({8'($urandom), LMPR_PORT}, "LMPR read", d);
            read_check({8'($urandom), HMPR_PORT}, "HMPR read", d);
            io_write({8'($urandom), BORDER_PORT}, 8'($urandom));
            @(posedge clk);
            keyboard <= 8'($urandom);
            ear      <= 1'($urandom);
            read_check({8'($urandom), BORDER_PORT}, "border read", d);
            read_check({8'($urandom), STATUS_PORT}, "status read", d);
            @(negedge clk);
            check_value(mic, border_m[3], "mic");
            check_value(beep, border_m[4], "beep");
            // 248 and 249 stand in for 253 and 255
            port = 8'($urandom_range(0, 249));
            if (port == 8'd248) port = 8'd253;
            if (port == 8'd249) port = 8'd255;
            read_check({8'($urandom), port}, "unlisted port read", d);
        end
    endtask

    task automatic sync_geometry();
        int n;
        @(negedge clk);
        while (hsync_pal !== 1'b1) @(negedge clk);
        while (hsync_pal !== 1'b0) @(negedge clk);
        n = 0;
        while (hsync_pal === 1'b0) begin
            n++;
            @(negedge clk);
        end
        check_value(n, 64, "hsync low width");
        while (hsync_pal === 1'b1) begin
            n++;
            @(negedge clk);
        end
        check_value(n, H_TOTAL, "hsync period");
        while (vsync_pal !== 1'b1) @(negedge clk);
        while (vsync_pal !== 1'b0) @(negedge clk);
        n = 0;
        while (vsync_pal === 1'b0) begin
            n++;
            @(negedge clk);
        end
        check_value(n, 4 * H_TOTAL, "vsync low width");
    endtask

    task automatic interrupt_lines();
        logic [7:0] line;
        logic [7:0] d;
        logic       prev;
        int         pulses;
        time        t0;
        time        t_end;
        line = 8'($urandom_range(0, 191));
        io_write({8'($urandom), STATUS_PORT}, line);
        @(negedge clk);
        // First full pulse that is not the frame interrupt
        do begin
            prev = int_n;
            @(negedge clk);
        end while (!(prev && !int_n) || vc_m == 9'(VS_LINE));
        t0 = $time;
        check_value(vc_m, {1'b0, line}, "line interrupt line");
        read_check({8'($urandom), STATUS_PORT}, "status in line interrupt", d);
        check_value(d[0], 1'b0, "status rint_n");
        do @(negedge clk); while (int_n !== 1'b1);
        check_value(int'(($time - t0) / CLK_NS), INT_CLKS, "line interrupt width");

        // Off-screen line, only the frame interrupt is left
        io_write({8'($urandom), STATUS_PORT}, 8'd200);
        do @(negedge clk); while (hc_m != 10'd300);
        t_end  = $time + FRAME_NS;
        pulses = 0;
        prev   = int_n;
        while ($time < t_end) begin
            @(negedge clk);
            if (prev && !int_n) begin
                pulses++;
                check_value(vc_m, VS_LINE, "frame interrupt line");
                read_check({8'($urandom), STATUS_PORT}, "status in frame interrupt", d);
                check_value(d[3], 1'b0, "status vint_n");
                check_value(d[0], 1'b1, "status rint_n off screen");
                @(negedge clk);
            end
            prev = int_n;
        end
        check_value(pulses, 1, "interrupts per frame");
    endtask

    task automatic border_colour();
        logic [3:0] idx;
        logic [7:0] d;
        for (int i = 0; i < 6; i++) begin
            idx = 4'($urandom);
            io_write({4'($urandom), idx, CLUT_PORT}, {1'b0, 7'($urandom)});
            io_write({8'($urandom), BORDER_PORT}, {2'b00, idx[3], 2'($urandom), idx[2:0]});
            // Visible border and line blanking, compared by the monitor
            repeat (2 * H_TOTAL) @(negedge clk);
        end
        while (vc_m != 9'(VB_START)) @(negedge clk);
        repeat (H_TOTAL) begin
            check_value({r, g, b, bright}, 7'd0, "rgb in vertical blanking");
            @(negedge clk);
        end
        io_write({8'($urandom), VMPR_PORT}, 8'h40 | 8'($urandom_range(0, 31)));
        // Fully lit entry, so a missing blank would show
        idx = 4'($urandom);
        io_write({4'($urandom), idx, CLUT_PORT}, 8'h7f);
        io_write({8'($urandom), BORDER_PORT}, {2'b10, idx[3], 2'($urandom), idx[2:0]});
        read_check({8'($urandom), BORDER_PORT}, "border read screen off", d);
        check_value(d[7], 1'b1, "screen_off bit");
        // Top line of the next frame has visible border
        while (vc_m != 9'd0) @(negedge clk);
        repeat (H_TOTAL) begin
            @(negedge clk);
            check_value({r, g, b, bright}, 7'd0, "rgb with screen off");
        end
    endtask

    //////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////
    initial begin
        void'($urandom(11));
        rst_n         = 1'b0;
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        cpuaddr       = '0;
        data_from_cpu = '0;
        keyboard      = '0;
        ear           = 1'b0;
        lmpr_m        = '0;
        hmpr_m        = '0;
        vmpr_m        = '0;
        border_m      = '0;
        line_m        = 8'hff;
        // Default ramp, entry 8 without bright
        for (int i = 0; i < 16; i++) begin
            clut_m[i] = {3'(i), (i > 8) ? 1'b1 : 1'b0, 3'(i)};
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        paging_cycles();
        register_readback();
        sync_geometry();
        interrupt_lines();
        border_colour();
        $display("Test OK");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within the expected frames");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    // Free-running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

/* source/asic_top.sv */
`timescale 1ns/1ps

module asic_top #(
    parameter int H_ACTIVE = asic_pkg::DEF_H_ACTIVE,
    parameter int R_BORDER = asic_pkg::DEF_R_BORDER,
    parameter int H_FPORCH = asic_pkg::DEF_H_FPORCH,
    parameter int H_SYNC   = asic_pkg::DEF_H_SYNC,
    parameter int H_BPORCH = asic_pkg::DEF_H_BPORCH,
    parameter int L_BORDER = asic_pkg::DEF_L_BORDER,
    parameter int V_ACTIVE = asic_pkg::DEF_V_ACTIVE,
    parameter int B_BORDER = asic_pkg::DEF_B_BORDER,
    parameter int V_FPORCH = asic_pkg::DEF_V_FPORCH,
    parameter int V_SYNC   = asic_pkg::DEF_V_SYNC,
    parameter int V_BPORCH = asic_pkg::DEF_V_BPORCH,
    parameter int T_BORDER = asic_pkg::DEF_T_BORDER
) (
    input  logic        clk,
    input  logic        rst_n,
    // CPU side
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic [15:0] cpuaddr,
    input  logic [7:0]  data_from_cpu,
    input  logic [7:0]  keyboard,
    input  logic        ear,
    output logic [7:0]  data_to_cpu,
    output logic        data_enable_n,
    // Memory side
    output logic [18:0] cpuramaddr,
    output logic        romcs_n,
    output logic        ramcs_n,
    output logic        ramwr_n,
    // Sound, video and interrupt
    output logic        mic,
    output logic        beep,
    output logic [1:0]  r,
    output logic [1:0]  g,
    output logic [1:0]  b,
    output logic        bright,
    output logic        csync,
    output logic        hsync_pal,
    output logic        vsync_pal,
    output logic        int_n
);
    import asic_pkg::*;

    cpu_bus_t    bus;
    page_ctrl_t  page_ctrl;
    video_ctrl_t video_ctrl;
    beam_t       beam;
    rgb_t        rgb;
    logic [7:0]  line_int;
    logic        vint_n;
    logic        rint_n;

    assign bus = '{mreq_n: mreq_n, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n,
                   addr: cpuaddr, wdata: data_from_cpu};

    port_regs port_regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus),
        .keyboard      (keyboard),
        .ear           (ear),
        .vint_n        (vint_n),
        .rint_n        (rint_n),
        .data_to_cpu   (data_to_cpu),
        .data_enable_n (data_enable_n),
        .page_ctrl     (page_ctrl),
        .video_ctrl    (video_ctrl),
        .line_int      (line_int),
        .mic           (mic),
        .beep          (beep)
    );

    mem_pager mem_pager_i (
        .bus        (bus),
        .page_ctrl  (page_ctrl),
        .romcs_n    (romcs_n),
        .ramcs_n    (ramcs_n),
        .ramwr_n    (ramwr_n),
        .cpuramaddr (cpuramaddr)
    );

    video_timing #(
        .H_ACTIVE (H_ACTIVE), .R_BORDER (R_BORDER), .H_FPORCH (H_FPORCH),
        .H_SYNC   (H_SYNC),   .H_BPORCH (H_BPORCH), .L_BORDER (L_BORDER),
        .V_ACTIVE (V_ACTIVE), .B_BORDER (B_BORDER), .V_FPORCH (V_FPORCH),
        .V_SYNC   (V_SYNC),   .V_BPORCH (V_BPORCH), .T_BORDER (T_BORDER)
    ) video_timing_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .line_int  (line_int),
        .beam      (beam),
        .hsync_pal (hsync_pal),
        .vsync_pal (vsync_pal),
        .csync     (csync),
        .vint_n    (vint_n),
        .rint_n    (rint_n)
    );

    palette_out #(
        .H_ACTIVE (H_ACTIVE), .R_BORDER (R_BORDER), .H_FPORCH (H_FPORCH),
        .H_SYNC   (H_SYNC),   .H_BPORCH (H_BPORCH), .L_BORDER (L_BORDER),
        .V_ACTIVE (V_ACTIVE), .B_BORDER (B_BORDER), .V_FPORCH (V_FPORCH),
        .V_SYNC   (V_SYNC),   .V_BPORCH (V_BPORCH), .T_BORDER (T_BORDER)
    ) palette_out_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .beam       (beam),
        .video_ctrl (video_ctrl),
        .rgb        (rgb)
    );

    assign r      = rgb.r;
    assign g      = rgb.g;
    assign b      = rgb.b;
    assign bright = rgb.bright;

    assign int_n = vint_n & rint_n;

endmodule

/* video/palette_out.sv */
`timescale 1ns/1ps

module palette_out #(
    parameter int H_ACTIVE = asic_pkg::DEF_H_ACTIVE,
    parameter int R_BORDER = asic_pkg::DEF_R_BORDER,
    parameter int H_FPORCH = asic_pkg::DEF_H_FPORCH,
    parameter int H_SYNC   = asic_pkg::DEF_H_SYNC,
    parameter int H_BPORCH = asic_pkg::DEF_H_BPORCH,
    parameter int L_BORDER = asic_pkg::DEF_L_BORDER,
    parameter int V_ACTIVE = asic_pkg::DEF_V_ACTIVE,
    parameter int B_BORDER = asic_pkg::DEF_B_BORDER,
    parameter int V_FPORCH = asic_pkg::DEF_V_FPORCH,
    parameter int V_SYNC   = asic_pkg::DEF_V_SYNC,
    parameter int V_BPORCH = asic_pkg::DEF_V_BPORCH,
    parameter int T_BORDER = asic_pkg::DEF_T_BORDER
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  asic_pkg::beam_t        beam,
    input  asic_pkg::video_ctrl_t  video_ctrl,
    output asic_pkg::rgb_t         rgb
);
    import asic_pkg::*;

    localparam int H_TOTAL  = H_ACTIVE + R_BORDER + H_FPORCH + H_SYNC + H_BPORCH + L_BORDER;
    localparam int V_TOTAL  = V_ACTIVE + B_BORDER + V_FPORCH + V_SYNC + V_BPORCH + T_BORDER;
    localparam int HB_END   = R_BORDER + H_FPORCH + H_SYNC + H_BPORCH;
    localparam int VB_START = V_ACTIVE + B_BORDER;
    localparam int VB_END   = VB_START + V_FPORCH + V_SYNC + V_BPORCH;

    clut_entry_t clut [16];
    clut_entry_t entry;
    logic        blank;

    // Power-on ramp, same colour on both levels, upper half bright
    function automatic clut_entry_t ramp_entry(input logic [3:0] idx);
        clut_entry_t e;
        e.g_hi   = idx[2];
        e.r_hi   = idx[1];
        e.b_hi   = idx[0];
        e.g_lo   = idx[2];
        e.r_lo   = idx[1];
        e.b_lo   = idx[0];
        // Entry 8 stays plain black
        e.bright = idx[3] && (idx[2:0] != 3'd0);
        return e;
    endfunction

    ////////////////////////////////
    // CLUT write port
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                clut[i] <= ramp_entry(4'(i));
            end
        end else if (video_ctrl.clut_we) begin
            clut[video_ctrl.clut_addr] <= video_ctrl.clut_data;
        end
    end

    ////////////////////////////////
    // Border colour with blanking
    ////////////////////////////////
    assign blank = video_ctrl.screen_off ||
                   (beam.hc >= R_BORDER && beam.hc < HB_END) ||
                   (beam.vc >= VB_START && beam.vc < VB_END);

    assign entry = clut[video_ctrl.border_index];

    always_comb begin
        if (blank) begin
            rgb = '0;
        end else begin
            rgb.r      = {entry.r_hi, entry.r_lo};
            rgb.g      = {entry.g_hi, entry.g_lo};
            rgb.b      = {entry.b_hi, entry.b_lo};
            rgb.bright = entry.bright;
        end
    end

    // Beam from the timing block stays inside the frame
    a_beam_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n) beam.hc < H_TOTAL && beam.vc < V_TOTAL
    );

endmodule

/* video/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = asic_pkg::DEF_H_ACTIVE,
    parameter int R_BORDER = asic_pkg::DEF_R_BORDER,
    parameter int H_FPORCH = asic_pkg::DEF_H_FPORCH,
    parameter int H_SYNC   = asic_pkg::DEF_H_SYNC,
    parameter int H_BPORCH = asic_pkg::DEF_H_BPORCH,
    parameter int L_BORDER = asic_pkg::DEF_L_BORDER,
    parameter int V_ACTIVE = asic_pkg::DEF_V_ACTIVE,
    parameter int B_BORDER = asic_pkg::DEF_B_BORDER,
    parameter int V_FPORCH = asic_pkg::DEF_V_FPORCH,
    parameter int V_SYNC   = asic_pkg::DEF_V_SYNC,
    parameter int V_BPORCH = asic_pkg::DEF_V_BPORCH,
    parameter int T_BORDER = asic_pkg::DEF_T_BORDER
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [7:0]       line_int,
    output asic_pkg::beam_t  beam,
    output logic             hsync_pal,
    output logic             vsync_pal,
    output logic             csync,
    output logic             vint_n,
    output logic             rint_n
);
    import asic_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + R_BORDER + H_FPORCH + H_SYNC + H_BPORCH + L_BORDER;
    localparam int V_TOTAL = V_ACTIVE + B_BORDER + V_FPORCH + V_SYNC + V_BPORCH + T_BORDER;
    localparam int HS_START = R_BORDER + H_FPORCH;
    localparam int VS_START = V_ACTIVE + B_BORDER + V_FPORCH;

    ////////////////////////////////
    // Beam counters
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beam.hc <= '0;
            beam.vc <= '0;
        end else if (beam.hc == 10'(H_TOTAL - 1)) begin
            beam.hc <= '0;
            if (beam.vc == 9'(V_TOTAL - 1)) begin
                beam.vc <= '0;
            end else begin
                beam.vc <= beam.vc + 9'd1;
            end
        end else begin
            beam.hc <= beam.hc + 10'd1;
        end
    end

    ////////////////////////////////
    // Syncs
    ////////////////////////////////
    assign hsync_pal = !(beam.hc >= HS_START && beam.hc < HS_START + H_SYNC);
    assign vsync_pal = !(beam.vc >= VS_START && beam.vc < VS_START + V_SYNC);

    // Serrated during vertical sync
    assign csync = hsync_pal ^ !vsync_pal;

    ////////////////////////////////
    // Interrupts
    ////////////////////////////////
    assign vint_n = !(beam.vc == 9'(VS_START) && beam.hc < INT_WINDOW);

    // Lines past 191 never raise an interrupt
    assign rint_n = !(line_int <= 8'd191 && {1'b0, line_int} == beam.vc &&
                      beam.hc < INT_WINDOW);

endmodule

/* source/mem_pager.sv */
`timescale 1ns/1ps

module mem_pager (
    input  asic_pkg::cpu_bus_t    bus,
    input  asic_pkg::page_ctrl_t  page_ctrl,
    output logic                  romcs_n,
    output logic                  ramcs_n,
    output logic                  ramwr_n,
    output logic [18:0]           cpuramaddr
);
    import asic_pkg::*;

    logic [1:0] section;
    page_t      page;

    // A = 0, B = 1, C = 2, D = 3
    assign section = bus.addr[15:14];

    ////////////////////////////////
    // Chip selects
    ////////////////////////////////
    always_comb begin
        romcs_n = 1'b1;
        ramcs_n = 1'b1;
        if (!bus.mreq_n) begin
            if ((section == 2'd0 && page_ctrl.rom_a_on) ||
                (section == 2'd3 && page_ctrl.rom_d_on)) begin
                romcs_n = 1'b0;
            end else if (!(bus.addr[15] && page_ctrl.external_mem)) begin
                // Upper 32K goes off-board when external memory is on
                ramcs_n = 1'b0;
            end
        end
    end

    ////////////////////////////////
    // Paged address
    ////////////////////////////////
    always_comb begin
        case (section)
            2'd0:    page = page_ctrl.low_page;
            2'd1:    page = page_ctrl.low_page + 5'd1;
            2'd2:    page = page_ctrl.high_page;
            default: page = page_ctrl.high_page + 5'd1;
        endcase
    end

    assign cpuramaddr = {page, bus.addr[13:0]};

    assign ramwr_n = ramcs_n || bus.wr_n ||
                     (section == 2'd0 && page_ctrl.write_protect_a);

endmodule

/* source/port_regs.sv */
`timescale 1ns/1ps

module port_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  asic_pkg::cpu_bus_t     bus,
    input  logic [7:0]             keyboard,
    input  logic                   ear,
    input  logic                   vint_n,
    input  logic                   rint_n,
    output logic [7:0]             data_to_cpu,
    output logic                   data_enable_n,
    output asic_pkg::page_ctrl_t   page_ctrl,
    output asic_pkg::video_ctrl_t  video_ctrl,
    output logic [7:0]             line_int,
    output logic                   mic,
    output logic                   beep
);
    import asic_pkg::*;

    lmpr_t    lmpr;
    hmpr_t    hmpr;
    vmpr_t    vmpr;
    border_t  border;
    io_port_e port;
    logic     io_wr;
    logic     io_rd;

    assign port  = io_port_e'(bus.addr[7:0]);
    assign io_wr = !bus.iorq_n && !bus.wr_n;
    assign io_rd = !bus.iorq_n && !bus.rd_n;

    ////////////////////////////////
    // Register writes
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lmpr     <= '0;
            hmpr     <= '0;
            vmpr     <= '0;
            border   <= '0;
            line_int <= 8'hff;
        end else if (io_wr) begin
            case (port)
                PORT_BORDER:      border   <= border_t'(bus.wdata);
                PORT_VMPR:        vmpr     <= vmpr_t'(bus.wdata);
                PORT_HMPR:        hmpr     <= hmpr_t'(bus.wdata);
                PORT_LMPR:        lmpr     <= lmpr_t'(bus.wdata);
                PORT_LINE_STATUS: line_int <= bus.wdata;
                default: ;
            endcase
        end
    end

    ////////////////////////////////
    // Control out to the other blocks
    ////////////////////////////////
    assign page_ctrl.low_page        = lmpr.low_page;
    assign page_ctrl.high_page       = hmpr.high_page;
    assign page_ctrl.rom_a_on        = !lmpr.rom_a_off;
    assign page_ctrl.rom_d_on        = lmpr.rom_d_on;
    assign page_ctrl.write_protect_a = lmpr.write_protect_a;
    assign page_ctrl.external_mem    = hmpr.external_mem;

    // Screen goes dark only in modes 3 and 4
    assign video_ctrl.screen_off   = border.off && vmpr.screen_mode[1];
    assign video_ctrl.border_index = {border.colour_hi, border.colour_lo};

    // CLUT entry number comes from the high address byte
    assign video_ctrl.clut_we   = io_wr && (port == PORT_CLUT);
    assign video_ctrl.clut_addr = bus.addr[11:8];
    assign video_ctrl.clut_data = clut_entry_t'(bus.wdata[6:0]);

    assign mic  = border.mic;
    assign beep = border.beep;

    ////////////////////////////////
    // CPU read mux
    ////////////////////////////////
    always_comb begin
        data_to_cpu   = 8'hff;
        data_enable_n = 1'b1;
        if (io_rd) begin
            data_enable_n = 1'b0;
            case (port)
                PORT_BORDER: begin
                    data_to_cpu = {video_ctrl.screen_off, ear, 1'b0, keyboard[4:0]};
                end
                PORT_LINE_STATUS: begin
                    data_to_cpu = {keyboard[7:5], 1'b1, vint_n, 1'b1, 1'b1, rint_n};
                end
                PORT_VMPR: data_to_cpu = vmpr;
                PORT_HMPR: data_to_cpu = hmpr;
                PORT_LMPR: data_to_cpu = lmpr;
                // Nothing answers here, leave the bus floating
                default: data_enable_n = 1'b1;
            endcase
        end
    end

endmodule

/* common/asic_pkg.sv */
package asic_pkg;

    ////////////////////////////////
    // I/O port map (low address byte)
    ////////////////////////////////
    typedef enum logic [7:0] {
        PORT_CLUT        = 8'd248,
        PORT_LINE_STATUS = 8'd249,
        PORT_LMPR        = 8'd250,
        PORT_HMPR        = 8'd251,
        PORT_VMPR        = 8'd252,
        PORT_BORDER      = 8'd254
    } io_port_e;

    typedef logic [4:0] page_t;

    ////////////////////////////////
    // Port register layouts
    ////////////////////////////////
    typedef struct packed {
        logic  write_protect_a;
        logic  rom_d_on;
        // Set means section A shows RAM
        logic  rom_a_off;
        page_t low_page;
    } lmpr_t;

    typedef struct packed {
        logic       external_mem;
        logic [1:0] clut_hi;
        page_t      high_page;
    } hmpr_t;

    typedef struct packed {
        logic       spare;
        logic [1:0] screen_mode;
        page_t      screen_page;
    } vmpr_t;

    typedef struct packed {
        logic       off;
        logic       unused;
        logic       colour_hi;
        logic       beep;
        logic       mic;
        logic [2:0] colour_lo;
    } border_t;

    ////////////////////////////////
    // Buses between blocks
    ////////////////////////////////
    typedef struct packed {
        logic        mreq_n;
        logic        iorq_n;
        logic        rd_n;
        logic        wr_n;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } cpu_bus_t;

    typedef struct packed {
        page_t low_page;
        page_t high_page;
        logic  rom_a_on;
        logic  rom_d_on;
        logic  write_protect_a;
        logic  external_mem;
    } page_ctrl_t;

    // One CLUT entry, as written through the CLUT port
    typedef struct packed {
        logic g_hi;
        logic r_hi;
        logic b_hi;
        logic bright;
        logic g_lo;
        logic r_lo;
        logic b_lo;
    } clut_entry_t;

    typedef struct packed {
        logic        screen_off;
        logic [3:0]  border_index;
        logic        clut_we;
        logic [3:0]  clut_addr;
        clut_entry_t clut_data;
    } video_ctrl_t;

    typedef struct packed {
        logic [9:0] hc;
        logic [8:0] vc;
    } beam_t;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
        logic       bright;
    } rgb_t;

    ////////////////////////////////
    // Default PAL geometry
    ////////////////////////////////
    localparam int DEF_H_ACTIVE = 512;
    localparam int DEF_R_BORDER = 64;
    localparam int DEF_H_FPORCH = 16;
    localparam int DEF_H_SYNC   = 64;
    localparam int DEF_H_BPORCH = 64;
    localparam int DEF_L_BORDER = 48;

    localparam int DEF_V_ACTIVE = 192;
    localparam int DEF_B_BORDER = 48;
    localparam int DEF_V_FPORCH = 4;
    localparam int DEF_V_SYNC   = 4;
    localparam int DEF_V_BPORCH = 16;
    localparam int DEF_T_BORDER = 48;

    // Interrupts last this many clocks from the start of a line
    localparam int INT_WINDOW = 256;

endpackage
